//--- verilog.f
+incdir+include
hw/screen_pkg.sv
hw/glyph_rom.sv
hw/glyph_blitter.sv
hw/table_sequencer.sv
hw/table_screen.sv
tb/screen_assertions.sv
tb/screen_checker.sv
tb/tb_table_screen.sv

//--- Makefile
# Verilator simulation of the poker table screen

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module tb_table_screen -o tb_table_screen
	./obj_dir/tb_table_screen | tee sim.log
	! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- tb/tb_table_screen.sv
// Table screen testbench
`include "screen_cfg.svh"

module tb_table_screen;
	timeunit 1ns;
	timeprecision 100ps;
	import screen_pkg::*;

	localparam int TABLE_HANDS  = 6;
	localparam int RANDOM_HANDS = 8;
	localparam int TOTAL_HANDS  = TABLE_HANDS + RANDOM_HANDS;
	localparam int LIMIT_CYCLES = (TOTAL_HANDS + 2) * 400;

	logic                   clk;
	logic                   rst;
	logic                   draw_request;
	logic [`CARD_W-1:0]     p1_card1;
	logic [`CARD_W-1:0]     p1_card2;
	logic [`CARD_W-1:0]     p2_card1;
	logic [`CARD_W-1:0]     p2_card2;
	logic [3*`CARD_W-1:0]   flop;
	logic [`CARD_W-1:0]     turn;
	logic [`CARD_W-1:0]     river;
	logic [`BANK_W-1:0]     p1_bank;
	logic [`BANK_W-1:0]     p2_bank;
	logic [`SCREEN_X_W-1:0] x;
	logic [`SCREEN_Y_W-1:0] y;
	colour_t                colour;
	logic                   write_en;
	logic                   frame_done;
	int                     pixel_errors;
	int                     protocol_errors;
	int                     frames_seen;
	int                     tb_errors;
	logic [31:0]            lfsr;

	// cards p1c1 p1c2 p2c1 p2c2 flop1 flop2 flop3 turn river, each {suit, rank}
	logic [9*`CARD_W-1:0]   hand_cards [TOTAL_HANDS];
	// p1 bank above p2 bank
	logic [2*`BANK_W-1:0]   hand_banks [TOTAL_HANDS];
	// second request in the middle of the frame
	logic                   hand_mid   [TOTAL_HANDS];

	table_screen u_dut (
		.clk(clk), .rst(rst), .draw_request(draw_request),
		.p1_card1(p1_card1), .p1_card2(p1_card2), .p2_card1(p2_card1), .p2_card2(p2_card2),
		.flop(flop), .turn(turn), .river(river), .p1_bank(p1_bank), .p2_bank(p2_bank),
		.x(x), .y(y), .colour(colour), .write_en(write_en), .frame_done(frame_done)
	);

	screen_checker u_checker (
		.clk(clk), .rst(rst), .draw_request(draw_request),
		.p1_card1(p1_card1), .p1_card2(p1_card2), .p2_card1(p2_card1), .p2_card2(p2_card2),
		.flop(flop), .turn(turn), .river(river), .p1_bank(p1_bank), .p2_bank(p2_bank),
		.x(x), .y(y), .colour(colour), .write_en(write_en), .frame_done(frame_done),
		.pixel_errors(pixel_errors), .protocol_errors(protocol_errors),
		.frames_seen(frames_seen)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic set_hand(input int i, input logic [9*`CARD_W-1:0] cards,
		input logic [2*`BANK_W-1:0] banks, input logic mid);
		hand_cards[i] = cards;
		hand_banks[i] = banks;
		hand_mid[i]   = mid;
	endtask

	task automatic load_table();
		// aces, face cards, all suits, banks 00 and ff
		set_hand(0, {6'h01, 6'h2d, 6'h1a, 6'h3b, 6'h0c, 6'h22, 6'h35, 6'h19, 6'h27}, 16'h00ff, 1'b0);
		// blank ranks 0, 14 and 15
		set_hand(1, {6'h00, 6'h1e, 6'h2f, 6'h30, 6'h0e, 6'h1f, 6'h20, 6'h3e, 6'h10}, 16'hff00, 1'b1);
		set_hand(2, {6'h23, 6'h34, 6'h05, 6'h16, 6'h28, 6'h39, 6'h0a, 6'h1b, 6'h2c}, 16'h5aa5, 1'b0);
		set_hand(3, {6'h3d, 6'h0b, 6'h1c, 6'h2a, 6'h31, 6'h06, 6'h17, 6'h29, 6'h3a}, 16'h1234, 1'b0);
		set_hand(4, {6'h02, 6'h12, 6'h22, 6'h32, 6'h03, 6'h13, 6'h23, 6'h33, 6'h04}, 16'h6789, 1'b1);
		set_hand(5, {6'h3c, 6'h2b, 6'h1a, 6'h09, 6'h38, 6'h27, 6'h16, 6'h05, 6'h34}, 16'hbcde, 1'b0);
	endtask

	task automatic make_random_hand(input int i);
		logic [31:0] bits;
		for (int k = 0; k < 9; k++)
		begin
			random_bits(`CARD_W, bits);
			hand_cards[i][(8 - k) * `CARD_W +: `CARD_W] = bits[`CARD_W-1:0];
		end
		random_bits(2 * `BANK_W, bits);
		hand_banks[i] = bits[2*`BANK_W-1:0];
		random_bits(1, bits);
		hand_mid[i] = bits[0];
	endtask

	task automatic start_frame(input int i);
		@(posedge clk);
		#2;
		{p1_card1, p1_card2, p2_card1, p2_card2} = hand_cards[i][9*`CARD_W-1:5*`CARD_W];
		flop = {hand_cards[i][2*`CARD_W +: `CARD_W], hand_cards[i][3*`CARD_W +: `CARD_W],
			hand_cards[i][4*`CARD_W +: `CARD_W]};
		turn  = hand_cards[i][`CARD_W +: `CARD_W];
		river = hand_cards[i][0 +: `CARD_W];
		{p1_bank, p2_bank} = hand_banks[i];
		draw_request = 1'b1;
		@(posedge clk);
		#2;
		draw_request = 1'b0;
	endtask

	task automatic repeat_request();
		@(posedge clk);
		#2;
		draw_request = 1'b1;
		@(posedge clk);
		#2;
		draw_request = 1'b0;
	endtask

	task automatic wait_frame_done();
		@(negedge clk);
		while (frame_done !== 1'b1)
			@(negedge clk);
	endtask

	initial
	begin
		rst = 1'b0;
		draw_request = 1'b0;
		p1_card1 = '0;
		p1_card2 = '0;
		p2_card1 = '0;
		p2_card2 = '0;
		flop = '0;
		turn = '0;
		river = '0;
		p1_bank = '0;
		p2_bank = '0;
		lfsr = 32'h2881;
		load_table();
		for (int i = TABLE_HANDS; i < TOTAL_HANDS; i++)
			make_random_hand(i);

		repeat (5) @(posedge clk);
		#2;
		rst = 1'b1;
		@(negedge clk);
		if (write_en !== 1'b0 || frame_done !== 1'b0 || x !== '0 || y !== '0
			|| colour !== colour_black)
		begin
			tb_errors++;
			$display("error at time %0t: outputs not cleared by reset", $time);
		end
		// idle stretch, no writes expected
		repeat (10) @(posedge clk);

		for (int i = 0; i < TOTAL_HANDS; i++)
		begin
			start_frame(i);
			if (hand_mid[i])
			begin
				repeat (100) @(posedge clk);
				repeat_request();
			end
			wait_frame_done();
		end
		repeat (20) @(posedge clk);

		if (frames_seen != TOTAL_HANDS)
		begin
			tb_errors++;
			$display("error: %0d frames requested but %0d frame_done pulses seen", TOTAL_HANDS,
				frames_seen);
		end
		$display("errors: %0d pixel, %0d protocol, %0d testbench", pixel_errors, protocol_errors,
			tb_errors);
		if (pixel_errors + protocol_errors + tb_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("timeout: run did not end within %0d clock cycles", LIMIT_CYCLES);
		$display("errors: %0d pixel, %0d protocol, %0d testbench", pixel_errors, protocol_errors,
			tb_errors);
		$display("Test failed");
		$finish;
	end

endmodule

//--- tb/screen_checker.sv
// Frame reference model and checker
`include "screen_cfg.svh"

module screen_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   draw_request,
	input  logic [`CARD_W-1:0]     p1_card1,
	input  logic [`CARD_W-1:0]     p1_card2,
	input  logic [`CARD_W-1:0]     p2_card1,
	input  logic [`CARD_W-1:0]     p2_card2,
	input  logic [3*`CARD_W-1:0]   flop,
	input  logic [`CARD_W-1:0]     turn,
	input  logic [`CARD_W-1:0]     river,
	input  logic [`BANK_W-1:0]     p1_bank,
	input  logic [`BANK_W-1:0]     p2_bank,
	input  logic [`SCREEN_X_W-1:0] x,
	input  logic [`SCREEN_Y_W-1:0] y,
	input  screen_pkg::colour_t    colour,
	input  logic                   write_en,
	input  logic                   frame_done,
	output int                     pixel_errors,
	output int                     protocol_errors,
	output int                     frames_seen
);
	timeunit 1ns;
	timeprecision 1ps;
	import screen_pkg::*;

	localparam int FRAME_PIXELS = `GLYPHS_PER_FRAME * `GLYPH_BITS;

	logic [`SCREEN_X_W-1:0] exp_x [$];
	logic [`SCREEN_Y_W-1:0] exp_y [$];
	colour_t                exp_c [$];
	logic                   busy;
	logic                   accept;
	int                     seen;

	function automatic logic [14:0] hex_bitmap(input logic [3:0] digit);
		case (digit)
			4'h0: return 15'b111_101_101_101_111;
			4'h1: return 15'b010_110_010_010_111;
			4'h2: return 15'b111_001_111_100_111;
			4'h3: return 15'b111_001_111_001_111;
			4'h4: return 15'b101_101_111_001_001;
			4'h5: return 15'b111_100_111_001_111;
			4'h6: return 15'b111_100_111_101_111;
			4'h7: return 15'b111_001_001_001_001;
			4'h8: return 15'b111_101_111_101_111;
			4'h9: return 15'b111_101_111_001_111;
			4'ha: return 15'b010_101_111_101_101;
			4'hb: return 15'b110_101_110_101_110;
			4'hc: return 15'b111_100_100_100_111;
			4'hd: return 15'b110_101_101_101_110;
			4'he: return 15'b111_100_111_100_111;
			default: return 15'b111_100_111_100_100;
		endcase
	endfunction

	// kind 0 is a rank, 1 a suit, 2 a hex digit
	function automatic logic [14:0] glyph_bitmap(input int kind, input logic [3:0] code);
		if (kind == 2)
			return hex_bitmap(code);
		if (kind == 1)
		begin
			case (code)
				4'd0: return 15'b010_111_111_010_111;
				4'd1: return 15'b010_111_101_010_111;
				4'd2: return 15'b000_101_111_111_010;
				4'd3: return 15'b010_111_101_111_010;
				default: return '0;
			endcase
		end
		case (code)
			4'd1: return hex_bitmap(4'ha);
			4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9: return hex_bitmap(code);
			4'd10: return 15'b111_010_010_010_010;
			4'd11: return 15'b001_001_001_101_111;
			4'd12: return 15'b010_101_101_110_011;
			4'd13: return 15'b101_110_100_110_101;
			default: return '0;
		endcase
	endfunction

	task automatic add_glyph(input logic [14:0] bitmap, input int ox, input int oy,
		input colour_t fg);
		for (int r = 0; r < `GLYPH_H; r++)
		begin
			for (int c = 0; c < `GLYPH_W; c++)
			begin
				exp_x.push_back(`SCREEN_X_W'(ox + c));
				exp_y.push_back(`SCREEN_Y_W'(oy + r));
				exp_c.push_back(bitmap[`GLYPH_BITS - 1 - (r * `GLYPH_W + c)] ? fg : colour_white);
			end
		end
	endtask

	task automatic build_frame();
		logic [`CARD_W-1:0] cards [9];
		int                 card_col [9];
		int                 card_row [9];
		int                 ox;
		int                 oy;
		colour_t            fg;
		cards = '{p1_card1, p1_card2, p2_card1, p2_card2, flop[5:0], flop[11:6], flop[17:12],
			turn, river};
		card_col = '{0, 1, 0, 1, 0, 1, 2, 0, 0};
		card_row = '{0, 0, 1, 1, 2, 2, 2, 3, 4};
		exp_x.delete();
		exp_y.delete();
		exp_c.delete();
		for (int i = 0; i < 9; i++)
		begin
			// hearts and diamonds have suit bit 1 set
			fg = cards[i][5] ? colour_red : colour_black;
			ox = `BOARD_X0 + 2 * card_col[i] * `GLYPH_PITCH_X;
			oy = `BOARD_Y0 + card_row[i] * `ROW_PITCH_Y;
			add_glyph(glyph_bitmap(0, cards[i][3:0]), ox, oy, fg);
			add_glyph(glyph_bitmap(1, {2'b00, cards[i][5:4]}), ox + `GLYPH_PITCH_X, oy, fg);
		end
		oy = `BOARD_Y0 + `ROW_PITCH_Y;
		add_glyph(glyph_bitmap(2, p1_bank[7:4]), `BANK_X0, `BOARD_Y0, colour_blue);
		add_glyph(glyph_bitmap(2, p1_bank[3:0]), `BANK_X0 + `GLYPH_PITCH_X, `BOARD_Y0, colour_blue);
		add_glyph(glyph_bitmap(2, p2_bank[7:4]), `BANK_X0, oy, colour_green);
		add_glyph(glyph_bitmap(2, p2_bank[3:0]), `BANK_X0 + `GLYPH_PITCH_X, oy, colour_green);
	endtask

	always @(posedge clk)
	begin
		if (!rst)
		begin
			busy = 1'b0;
			if (write_en === 1'b1 || frame_done === 1'b1)
			begin
				protocol_errors++;
				$display("error at time %0t: write_en or frame_done high in reset", $time);
			end
		end
		else
		begin
			// a request during a frame is ignored by the DUT
			accept = draw_request && !busy;
			if (write_en)
			begin
				if (!busy)
				begin
					protocol_errors++;
					$display("error at time %0t: write to (%0d,%0d) outside a frame", $time, x, y);
				end
				else if (seen >= FRAME_PIXELS)
				begin
					protocol_errors++;
					$display("error at time %0t: more than %0d writes in one frame", $time,
						FRAME_PIXELS);
				end
				else if (x !== exp_x[seen] || y !== exp_y[seen] || colour !== exp_c[seen])
				begin
					pixel_errors++;
					$display("FAILED at time %0t: pixel %0d expected (%0d,%0d) colour %b, seen (%0d,%0d) colour %b",
						$time, seen, exp_x[seen], exp_y[seen], exp_c[seen], x, y, colour);
				end
				seen++;
			end
			if (frame_done)
			begin
				frames_seen++;
				if (!busy)
				begin
					protocol_errors++;
					$display("error at time %0t: frame_done outside a frame", $time);
				end
				else if (seen != FRAME_PIXELS)
				begin
					protocol_errors++;
					$display("error at time %0t: frame_done after %0d of %0d writes", $time, seen,
						FRAME_PIXELS);
				end
				busy = 1'b0;
			end
			if (accept)
			begin
				build_frame();
				seen = 0;
				busy = 1'b1;
			end
		end
	end

endmodule

//--- tb/screen_assertions.sv
// Blitter write assertions
`include "screen_cfg.svh"

module screen_assertions (
	input logic clk,
	input logic rst,
	input logic start,
	input logic write_en,
	input logic glyph_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// writes seen so far in the current burst
	int run_len;

	always @(posedge clk or negedge rst)
	begin
		if (!rst)
			run_len <= 0;
		else if (write_en)
			run_len <= run_len + 1;
		else
			run_len <= 0;
	end

	no_write_on_done: assert property (@(posedge clk) disable iff (!rst)
		!(write_en && glyph_done))
		else $error("write_en and glyph_done high in the same cycle");

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		glyph_done |=> !glyph_done)
		else $error("glyph_done high for more than one cycle");

	write_after_start: assert property (@(posedge clk) disable iff (!rst)
		start |=> write_en)
		else $error("no write on the cycle after start");

	// burst never longer than one glyph
	burst_max: assert property (@(posedge clk) disable iff (!rst)
		write_en |-> run_len < `GLYPH_BITS)
		else $error("write burst longer than one glyph");

	// and never cut short
	burst_min: assert property (@(posedge clk) disable iff (!rst)
		(!write_en && run_len != 0) |-> run_len == `GLYPH_BITS)
		else $error("write burst shorter than one glyph");

endmodule

bind glyph_blitter screen_assertions u_assertions (
	.clk(clk), .rst(rst), .start(start), .write_en(write_en), .glyph_done(glyph_done)
);

//--- hw/table_screen.sv
// Poker table frame renderer
`include "screen_cfg.svh"

module table_screen (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   draw_request,
	input  logic [`CARD_W-1:0]     p1_card1,
	input  logic [`CARD_W-1:0]     p1_card2,
	input  logic [`CARD_W-1:0]     p2_card1,
	input  logic [`CARD_W-1:0]     p2_card2,
	input  logic [3*`CARD_W-1:0]   flop,
	input  logic [`CARD_W-1:0]     turn,
	input  logic [`CARD_W-1:0]     river,
	input  logic [`BANK_W-1:0]     p1_bank,
	input  logic [`BANK_W-1:0]     p2_bank,
	output logic [`SCREEN_X_W-1:0] x,
	output logic [`SCREEN_Y_W-1:0] y,
	output screen_pkg::colour_t    colour,
	output logic                   write_en,
	output logic                   frame_done
);
	import screen_pkg::*;

	glyph_kind_t            glyph_kind;
	logic [3:0]             glyph_code;
	glyph_t                 glyph;
	logic [`SCREEN_X_W-1:0] origin_x;
	logic [`SCREEN_Y_W-1:0] origin_y;
	colour_t                fg_colour;
	logic                   start;
	logic                   glyph_done;

	table_sequencer u_sequencer (
		.clk(clk), .rst(rst), .draw_request(draw_request),
		.p1_card1(p1_card1), .p1_card2(p1_card2), .p2_card1(p2_card1), .p2_card2(p2_card2),
		.flop(flop), .turn(turn), .river(river), .p1_bank(p1_bank), .p2_bank(p2_bank),
		.glyph_done(glyph_done), .glyph_kind(glyph_kind), .glyph_code(glyph_code),
		.origin_x(origin_x), .origin_y(origin_y), .fg_colour(fg_colour),
		.start(start), .frame_done(frame_done)
	);

	glyph_rom u_rom (.glyph_kind(glyph_kind), .glyph_code(glyph_code), .glyph(glyph));

	glyph_blitter u_blitter (
		.clk(clk), .rst(rst), .start(start), .glyph(glyph),
		.origin_x(origin_x), .origin_y(origin_y), .fg_colour(fg_colour),
		.x(x), .y(y), .colour(colour), .write_en(write_en), .glyph_done(glyph_done)
	);

endmodule

//--- hw/table_sequencer.sv
// Table frame sequencer
`include "screen_cfg.svh"

module table_sequencer (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     draw_request,
	input  logic [`CARD_W-1:0]       p1_card1,
	input  logic [`CARD_W-1:0]       p1_card2,
	input  logic [`CARD_W-1:0]       p2_card1,
	input  logic [`CARD_W-1:0]       p2_card2,
	input  logic [3*`CARD_W-1:0]     flop,
	input  logic [`CARD_W-1:0]       turn,
	input  logic [`CARD_W-1:0]       river,
	input  logic [`BANK_W-1:0]       p1_bank,
	input  logic [`BANK_W-1:0]       p2_bank,
	input  logic                     glyph_done,
	output screen_pkg::glyph_kind_t  glyph_kind,
	output logic [3:0]               glyph_code,
	output logic [`SCREEN_X_W-1:0]   origin_x,
	output logic [`SCREEN_Y_W-1:0]   origin_y,
	output screen_pkg::colour_t      fg_colour,
	output logic                     start,
	output logic                     frame_done
);
	import screen_pkg::*;

	seq_state_t             state;
	logic [4:0]             glyph_idx;
	logic [3:0]             card_num;
	logic [`CARD_W-1:0]     cur_card;
	logic [1:0]             slot_col;
	logic [2:0]             slot_row;
	logic                   is_card;
	logic [1:0]             bank_sel;
	logic [3:0]             bank_digit;
	glyph_kind_t            next_kind;
	logic [3:0]             next_code;
	logic [`SCREEN_X_W-1:0] next_x;
	logic [`SCREEN_Y_W-1:0] next_y;
	colour_t                next_colour;

	// two glyphs per card, rank first
	assign card_num = glyph_idx[4:1];
	// last four glyphs are the bank digits
	assign is_card  = (glyph_idx < 5'(`GLYPHS_PER_FRAME - 4));
	// p1 high, p1 low, p2 high, p2 low
	assign bank_sel = glyph_idx[1:0] - 2'd2;

	always_comb
	begin
		slot_col = 2'd0;
		slot_row = 3'd0;
		case (card_num)
			4'd0: cur_card = p1_card1;
			4'd1:
			begin
				cur_card = p1_card2;
				slot_col = 2'd1;
			end
			4'd2:
			begin
				cur_card = p2_card1;
				slot_row = 3'd1;
			end
			4'd3:
			begin
				cur_card = p2_card2;
				slot_col = 2'd1;
				slot_row = 3'd1;
			end
			4'd4:
			begin
				cur_card = flop[`CARD_W-1:0];
				slot_row = 3'd2;
			end
			4'd5:
			begin
				cur_card = flop[2*`CARD_W-1:`CARD_W];
				slot_col = 2'd1;
				slot_row = 3'd2;
			end
			4'd6:
			begin
				cur_card = flop[3*`CARD_W-1:2*`CARD_W];
				slot_col = 2'd2;
				slot_row = 3'd2;
			end
			4'd7:
			begin
				cur_card = turn;
				slot_row = 3'd3;
			end
			default:
			begin
				cur_card = river;
				slot_row = 3'd4;
			end
		endcase

		case (bank_sel)
			2'd0: bank_digit = p1_bank[7:4];
			2'd1: bank_digit = p1_bank[3:0];
			2'd2: bank_digit = p2_bank[7:4];
			default: bank_digit = p2_bank[3:0];
		endcase

		if (is_card)
		begin
			next_kind   = glyph_idx[0] ? kind_suit : kind_rank;
			next_code   = glyph_idx[0] ? {2'b00, cur_card[5:4]} : cur_card[3:0];
			next_x      = `SCREEN_X_W'(`BOARD_X0 + (slot_col * 2 + glyph_idx[0]) * `GLYPH_PITCH_X);
			next_y      = `SCREEN_Y_W'(`BOARD_Y0 + slot_row * `ROW_PITCH_Y);
			// suit bit 1 marks hearts and diamonds
			next_colour = cur_card[`CARD_W-1] ? colour_red : colour_black;
		end
		else
		begin
			next_kind   = kind_hex;
			next_code   = bank_digit;
			next_x      = `SCREEN_X_W'(`BANK_X0 + bank_sel[0] * `GLYPH_PITCH_X);
			next_y      = `SCREEN_Y_W'(`BOARD_Y0 + bank_sel[1] * `ROW_PITCH_Y);
			next_colour = bank_sel[1] ? colour_green : colour_blue;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state     <= seq_idle;
			glyph_idx <= '0;
		end
		else
		begin
			case (state)
				seq_idle:
					if (draw_request)
					begin
						glyph_idx <= '0;
						state     <= seq_load;
					end
				seq_load:
					state <= seq_start;
				seq_start:
					state <= seq_wait;
				seq_wait:
					if (glyph_done)
					begin
						if (glyph_idx == 5'(`GLYPHS_PER_FRAME - 1))
							state <= seq_finish;
						else
						begin
							glyph_idx <= glyph_idx + 5'd1;
							state     <= seq_load;
						end
					end
				default:
					state <= seq_idle;
			endcase
		end
	end

	// glyph parameters held steady from load until the next load
	always_ff @(posedge clk)
	begin
		if (state == seq_load)
		begin
			glyph_kind <= next_kind;
			glyph_code <= next_code;
			origin_x   <= next_x;
			origin_y   <= next_y;
			fg_colour  <= next_colour;
		end
	end

	assign start      = (state == seq_start);
	assign frame_done = (state == seq_finish);

endmodule

//--- hw/glyph_blitter.sv
// Glyph blitter
`include "screen_cfg.svh"

module glyph_blitter (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  screen_pkg::glyph_t     glyph,
	input  logic [`SCREEN_X_W-1:0] origin_x,
	input  logic [`SCREEN_Y_W-1:0] origin_y,
	input  screen_pkg::colour_t    fg_colour,
	output logic [`SCREEN_X_W-1:0] x,
	output logic [`SCREEN_Y_W-1:0] y,
	output screen_pkg::colour_t    colour,
	output logic                   write_en,
	output logic                   glyph_done
);
	import screen_pkg::*;

	blit_state_t state;
	logic [1:0]  col;
	logic [2:0]  row;
	logic [3:0]  pixel_idx;
	logic        pixel_on;
	logic        walk_end;
	logic        emit;

	// position of the current pixel inside the bitmap
	assign pixel_idx = 4'(row * `GLYPH_W + col);
	assign pixel_on  = glyph[`GLYPH_BITS - 1 - pixel_idx];

	// row counter runs one past the last row when the walk is over
	assign walk_end = (row == 3'(`GLYPH_H));

	// first pixel goes out on the start edge so writes follow start directly
	assign emit = (state == blit_idle) ? start : !walk_end;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state      <= blit_idle;
			col        <= '0;
			row        <= '0;
			x          <= '0;
			y          <= '0;
			colour     <= colour_black;
			write_en   <= 1'b0;
			glyph_done <= 1'b0;
		end
		else
		begin
			write_en   <= emit;
			glyph_done <= (state == blit_drawing) && walk_end;

			if (emit)
			begin
				x      <= origin_x + `SCREEN_X_W'(col);
				y      <= origin_y + `SCREEN_Y_W'(row);
				colour <= pixel_on ? fg_colour : colour_white;
				// left to right, then down one row
				if (col == 2'(`GLYPH_W - 1))
				begin
					col <= '0;
					row <= row + 3'd1;
				end
				else
				begin
					col <= col + 2'd1;
				end
			end

			case (state)
				blit_idle:
					if (start)
						state <= blit_drawing;
				blit_drawing:
					if (walk_end)
					begin
						state <= blit_idle;
						row   <= '0;
					end
				default:
					state <= blit_idle;
			endcase
		end
	end

endmodule

//--- hw/glyph_rom.sv
// Glyph font lookup
module glyph_rom (
	input  screen_pkg::glyph_kind_t glyph_kind,
	input  logic [3:0]              glyph_code,
	output screen_pkg::glyph_t      glyph
);
	import screen_pkg::*;

	// 3x5 hex digits, also reused for card ranks A and 2-9
	function automatic glyph_t hex_font(input logic [3:0] digit);
		case (digit)
			4'h0: return 15'b111_101_101_101_111;
			4'h1: return 15'b010_110_010_010_111;
			4'h2: return 15'b111_001_111_100_111;
			4'h3: return 15'b111_001_111_001_111;
			4'h4: return 15'b101_101_111_001_001;
			4'h5: return 15'b111_100_111_001_111;
			4'h6: return 15'b111_100_111_101_111;
			4'h7: return 15'b111_001_001_001_001;
			4'h8: return 15'b111_101_111_101_111;
			4'h9: return 15'b111_101_111_001_111;
			4'ha: return 15'b010_101_111_101_101;
			4'hb: return 15'b110_101_110_101_110;
			4'hc: return 15'b111_100_100_100_111;
			4'hd: return 15'b110_101_101_101_110;
			4'he: return 15'b111_100_111_100_111;
			default: return 15'b111_100_111_100_100;
		endcase
	endfunction

	always_comb
	begin
		glyph = '0;
		case (glyph_kind)
			kind_rank:
				case (glyph_code)
					// ace
					4'd1: glyph = hex_font(4'ha);
					4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9:
						glyph = hex_font(glyph_code);
					// ten, jack, queen, king
					4'd10: glyph = 15'b111_010_010_010_010;
					4'd11: glyph = 15'b001_001_001_101_111;
					4'd12: glyph = 15'b010_101_101_110_011;
					4'd13: glyph = 15'b101_110_100_110_101;
					default: glyph = '0;
				endcase
			kind_suit:
				case (glyph_code)
					// spades, clubs, hearts, diamonds
					4'd0: glyph = 15'b010_111_111_010_111;
					4'd1: glyph = 15'b010_111_101_010_111;
					4'd2: glyph = 15'b000_101_111_111_010;
					4'd3: glyph = 15'b010_111_101_111_010;
					default: glyph = '0;
				endcase
			kind_hex:
				glyph = hex_font(glyph_code);
			default:
				glyph = '0;
		endcase
	end

endmodule

//--- hw/screen_pkg.sv
// Table screen types
`include "screen_cfg.svh"

package screen_pkg;

	// 3-bit display colours
	typedef enum logic [2:0] {
		colour_black = 3'b000,
		colour_red   = 3'b001,
		colour_green = 3'b010,
		colour_blue  = 3'b100,
		colour_white = 3'b111
	} colour_t;

	// font table select
	typedef enum logic [1:0] {
		kind_rank = 2'd0,
		kind_suit = 2'd1,
		kind_hex  = 2'd2
	} glyph_kind_t;

	typedef enum logic [2:0] {
		seq_idle   = 3'd0,
		seq_load   = 3'd1,
		seq_start  = 3'd2,
		seq_wait   = 3'd3,
		seq_finish = 3'd4
	} seq_state_t;

	typedef enum logic {
		blit_idle    = 1'b0,
		blit_drawing = 1'b1
	} blit_state_t;

	// bit 14 is the top-left pixel, row-major
	typedef logic [`GLYPH_BITS-1:0] glyph_t;

endpackage

//--- include/screen_cfg.svh
// Table screen configuration
`ifndef SCREEN_CFG_SVH
`define SCREEN_CFG_SVH

// display coordinate widths
`define SCREEN_X_W 8
`define SCREEN_Y_W 7

// glyph geometry
`define GLYPH_W 3
`define GLYPH_H 5
`define GLYPH_BITS 15

// card is a 4-bit rank below a 2-bit suit
`define CARD_W 6

// bank is two hex digits
`define BANK_W 8

// layout origin of the first card glyph
`define BOARD_X0 20
`define BOARD_Y0 20

// step between glyphs in a row
`define GLYPH_PITCH_X 4

// step between rows of glyphs
`define ROW_PITCH_Y 6

// column of the high bank digit
`define BANK_X0 38

// 18 card glyphs then 4 bank digits
`define GLYPHS_PER_FRAME 22

`endif
